// ==== src/coh_pkg.sv ====
package coh_pkg;

    parameter int addr_w = 32;
    parameter int id_w = 2;

    // receiver id 3 addresses every cache
    parameter logic [id_w-1:0] broadcast_id = 2'd3;

    // bit 2 set marks a request
    typedef enum logic [3:0] {
        wr_ack       = 4'b0000,
        rd_ack       = 4'b0010,
        rd_share_ack = 4'b0011,
        wr_req       = 4'b0100,
        rd_req       = 4'b0101
    } msg_op_e;

    typedef enum logic [2:0] {
        acc_lookup     = 3'b000,
        acc_downgrade  = 3'b001,
        acc_invalidate = 3'b011
    } acc_cmd_e;

    typedef logic [2:0] acc_status_t; // 0 is a miss, anything else a hit

    typedef struct packed {
        msg_op_e             op;
        logic [id_w-1:0]     ta;   // transmitter
        logic [id_w-1:0]     ra;   // receiver
        logic [addr_w-1:0]   addr;
    } coh_msg_t;

    parameter int msg_w = $bits(coh_msg_t);

endpackage

// ==== src/coh_rr_arbiter.sv ====
`timescale 1ns/1ps

module coh_rr_arbiter #(
    parameter int n_req = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [n_req-1:0] req,
    input  logic             advance,
    output logic [n_req-1:0] gnt
);

    localparam int ptr_w = (n_req > 1) ? $clog2(n_req) : 1;

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] gnt_idx;
    logic             found;

    // first requester at or after ptr
    always_comb begin
        int idx;
        gnt     = '0;
        gnt_idx = ptr;
        found   = 1'b0;
        for (int k = 0; k < n_req; k++) begin
            idx = (int'(ptr) + k) % n_req;
            if (!found && req[idx]) begin
                found        = 1'b1;
                gnt[idx]     = 1'b1;
                gnt_idx      = ptr_w'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance && found) begin
            ptr <= (gnt_idx == ptr_w'(n_req - 1)) ? '0 : gnt_idx + 1'b1; // move past winner
        end
    end

endmodule

// ==== src/coh_sync_fifo.sv ====
`timescale 1ns/1ps

module coh_sync_fifo #(
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             pop,
    input  coh_pkg::coh_msg_t wdata,
    output coh_pkg::coh_msg_t rdata,
    output logic             full,
    output logic             empty
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    coh_pkg::coh_msg_t mem [depth];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic          push_ok;
    logic          pop_ok;

    assign full    = (count == cw'(depth));
    assign empty   = (count == '0);
    assign push_ok = push && !full;  // push into a full queue is lost
    assign pop_ok  = pop && !empty;
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cw'(push_ok) - cw'(pop_ok);
        end
    end

endmodule

// ==== src/coh_req_engine.sv ====
`timescale 1ns/1ps

module coh_req_engine #(
    parameter int cache_id  = 0,
    parameter int cache_num = 2,
    parameter bit is_read   = 1'b0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_0,
    input  logic                       req_1,
    input  logic [3:0]                 op_0,
    input  logic [3:0]                 op_1,
    input  logic [coh_pkg::addr_w-1:0] index_0,
    input  logic [coh_pkg::addr_w-1:0] index_1,
    output logic                       gnt_0,
    output logic                       gnt_1,
    output logic                       valid_0,
    output logic                       valid_1,
    output coh_pkg::msg_op_e           rsp,
    output logic                       bus_req,
    input  logic                       bus_gnt,
    output coh_pkg::coh_msg_t          bus_msg,
    input  logic                       msg_in_valid,
    input  coh_pkg::coh_msg_t          msg_in
);

    localparam coh_pkg::msg_op_e req_op = is_read ? coh_pkg::rd_req : coh_pkg::wr_req;
    localparam logic [cache_num-1:0] own_bit = cache_num'(1) << cache_id;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK, DONE} state_e;

    state_e                       state;
    state_e                       state_nxt;
    logic [1:0]                   port_req;
    logic [1:0]                   port_gnt;
    logic                         owner;      // 1 means port 1
    coh_pkg::msg_op_e             op_q;
    logic [coh_pkg::addr_w-1:0]   index_q;
    logic [cache_num-1:0]         ack_map;
    logic                         shared;
    logic                         class_ack;
    logic                         ack_hit;

    assign port_req[0] = req_0 && (op_0 == req_op) && (state == IDLE);
    assign port_req[1] = req_1 && (op_1 == req_op) && (state == IDLE);

    coh_rr_arbiter #(.n_req(2)) u_port_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (port_req),
        .advance (|port_gnt),
        .gnt     (port_gnt)
    );

    assign gnt_0 = port_gnt[0];
    assign gnt_1 = port_gnt[1];

    assign class_ack = is_read ? (msg_in.op == coh_pkg::rd_ack || msg_in.op == coh_pkg::rd_share_ack)
                               : (msg_in.op == coh_pkg::wr_ack);
    assign ack_hit   = msg_in_valid && class_ack && (msg_in.ra == coh_pkg::id_w'(cache_id))
                       && (state == REQ || state == WAIT_ACK);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (|port_gnt) state_nxt = REQ;
            REQ:      if (bus_gnt) state_nxt = WAIT_ACK;
            WAIT_ACK: if (&ack_map) state_nxt = DONE;
            DONE:     state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            owner   <= 1'b0;
            ack_map <= own_bit;
            shared  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (|port_gnt) begin
                owner <= port_gnt[1];
            end
            if (state == IDLE) begin
                ack_map <= own_bit;    // own cache never answers
                shared  <= 1'b0;
            end else if (ack_hit) begin
                for (int i = 0; i < cache_num; i++) begin
                    if (msg_in.ta == coh_pkg::id_w'(i)) begin
                        ack_map[i] <= 1'b1;
                    end
                end
                if (msg_in.op == coh_pkg::rd_share_ack) begin
                    shared <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|port_gnt) begin
            op_q    <= coh_pkg::msg_op_e'(port_gnt[1] ? op_1 : op_0);
            index_q <= port_gnt[1] ? index_1 : index_0;
        end
    end

    assign bus_req      = (state == REQ);
    assign bus_msg.op   = op_q;
    assign bus_msg.ta   = coh_pkg::id_w'(cache_id);
    assign bus_msg.ra   = coh_pkg::broadcast_id;
    assign bus_msg.addr = index_q;

    assign valid_0 = (state == DONE) && !owner;
    assign valid_1 = (state == DONE) && owner;

    always_comb begin
        rsp = coh_pkg::wr_ack;
        if (state == DONE && is_read) begin
            rsp = shared ? coh_pkg::rd_share_ack : coh_pkg::rd_ack;
        end
    end

endmodule

// ==== src/coh_snoop_responder.sv ====
`timescale 1ns/1ps

module coh_snoop_responder #(
    parameter int cache_id  = 0,
    parameter int cache_num = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       msg_in_valid,
    input  coh_pkg::coh_msg_t          msg_in,
    output logic                       acc_req,
    output coh_pkg::acc_cmd_e          acc_cmd,
    output logic [coh_pkg::addr_w-1:0] acc_index,
    input  logic                       acc_gnt,
    input  coh_pkg::acc_status_t       acc_status,
    output logic                       bus_req,
    input  logic                       bus_gnt,
    output coh_pkg::coh_msg_t          bus_msg
);

    typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_UPDATE, S_REPLY} state_e;

    state_e            state;
    state_e            state_nxt;
    coh_pkg::coh_msg_t head;
    logic              push;
    logic              pop;
    logic              full;
    logic              empty;
    logic              hit_q;
    logic              head_wr;

    // requests from the other caches only
    assign push = msg_in_valid && msg_in.op[2] && (msg_in.ta != coh_pkg::id_w'(cache_id)) && !full;
    assign pop  = (state == S_REPLY) && bus_gnt;

    coh_sync_fifo #(.depth(2 * cache_num)) u_snoop_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push),
        .pop   (pop),
        .wdata (msg_in),
        .rdata (head),
        .full  (full),
        .empty (empty)
    );

    assign head_wr = (head.op == coh_pkg::wr_req);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (!empty) state_nxt = S_LOOKUP;
            S_LOOKUP: if (acc_gnt) state_nxt = (acc_status != '0) ? S_UPDATE : S_REPLY;
            S_UPDATE: if (acc_gnt) state_nxt = S_REPLY;
            S_REPLY:  if (bus_gnt) state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            hit_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == S_LOOKUP && acc_gnt) begin
                hit_q <= (acc_status != '0); // dirty counts as plain hit
            end
        end
    end

    assign acc_req   = (state == S_LOOKUP) || (state == S_UPDATE);
    assign acc_index = head.addr;

    always_comb begin
        acc_cmd = coh_pkg::acc_lookup;
        if (state == S_UPDATE) begin
            acc_cmd = head_wr ? coh_pkg::acc_invalidate : coh_pkg::acc_downgrade;
        end
    end

    assign bus_req = (state == S_REPLY);

    always_comb begin
        if (head_wr) begin
            bus_msg.op = coh_pkg::wr_ack;
        end else begin
            bus_msg.op = hit_q ? coh_pkg::rd_share_ack : coh_pkg::rd_ack;
        end
        bus_msg.ta   = coh_pkg::id_w'(cache_id);
        bus_msg.ra   = head.ta;          // back to the requester
        bus_msg.addr = head.addr;
    end

endmodule

// ==== src/coh_bus_arbiter.sv ====
`timescale 1ns/1ps

module coh_bus_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_wr,
    input  logic              req_rd,
    input  logic              req_snp,
    input  coh_pkg::coh_msg_t msg_wr,
    input  coh_pkg::coh_msg_t msg_rd,
    input  coh_pkg::coh_msg_t msg_snp,
    output logic              gnt_wr,
    output logic              gnt_rd,
    output logic              gnt_snp,
    output logic              bus_req,
    output coh_pkg::coh_msg_t bus_msg,
    input  logic              bus_gnt
);

    logic [2:0] req;
    logic [2:0] arb_req;
    logic [2:0] sel;
    logic [2:0] sel_q;
    logic       locked;

    assign req     = {req_snp, req_rd, req_wr};
    assign arb_req = locked ? sel_q : req;  // keep the winner until the bus takes it
    assign bus_req = |req;

    coh_rr_arbiter #(.n_req(3)) u_bus_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (arb_req),
        .advance (bus_gnt),
        .gnt     (sel)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked <= 1'b0;
            sel_q  <= '0;
        end else begin
            locked <= bus_req && !bus_gnt;
            sel_q  <= sel;
        end
    end

    assign gnt_wr  = sel[0] && bus_gnt;
    assign gnt_rd  = sel[1] && bus_gnt;
    assign gnt_snp = sel[2] && bus_gnt;

    always_comb begin
        case (sel)
            3'b001:  bus_msg = msg_wr;
            3'b010:  bus_msg = msg_rd;
            3'b100:  bus_msg = msg_snp;
            default: bus_msg = '0;
        endcase
    end

endmodule

// ==== src/coh_msg_ctrl.sv ====
`timescale 1ns/1ps

module coh_msg_ctrl #(
    parameter int cache_id  = 0,
    parameter int cache_num = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        msg_req_0,
    input  logic [3:0]                  msg_0,
    input  logic [coh_pkg::addr_w-1:0]  msg_index_0,
    output logic                        msg_gnt_0,
    output logic [3:0]                  msg_rsp_0,
    output logic                        msg_valid_0,
    input  logic                        msg_req_1,
    input  logic [3:0]                  msg_1,
    input  logic [coh_pkg::addr_w-1:0]  msg_index_1,
    output logic                        msg_gnt_1,
    output logic [3:0]                  msg_rsp_1,
    output logic                        msg_valid_1,
    output logic                        acc_req,
    output logic [2:0]                  acc_cmd,
    output logic [coh_pkg::addr_w-1:0]  acc_index,
    input  logic                        acc_gnt,
    input  logic [2:0]                  acc_status,
    output logic                        msg_req,
    input  logic                        msg_gnt,
    output logic [coh_pkg::msg_w-1:0]   msg,
    input  logic                        msg_in_valid,
    input  logic [coh_pkg::msg_w-1:0]   msg_in
);

    coh_pkg::coh_msg_t msg_in_s;
    coh_pkg::coh_msg_t msg_out_s;
    coh_pkg::coh_msg_t wr_msg;
    coh_pkg::coh_msg_t rd_msg;
    coh_pkg::coh_msg_t snp_msg;
    coh_pkg::msg_op_e  wr_rsp;
    coh_pkg::msg_op_e  rd_rsp;

    logic wr_req, wr_bus_gnt, rd_req, rd_bus_gnt, snp_req, snp_bus_gnt;
    logic wr_gnt_0, wr_gnt_1, wr_valid_0, wr_valid_1;
    logic rd_gnt_0, rd_gnt_1, rd_valid_0, rd_valid_1;

    assign msg_in_s = msg_in;
    assign msg      = msg_out_s;

    coh_req_engine #(.cache_id(cache_id), .cache_num(cache_num), .is_read(1'b0)) u_wr_engine (
        .clk (clk), .rst_n (rst_n),
        .req_0 (msg_req_0), .req_1 (msg_req_1), .op_0 (msg_0), .op_1 (msg_1),
        .index_0 (msg_index_0), .index_1 (msg_index_1),
        .gnt_0 (wr_gnt_0), .gnt_1 (wr_gnt_1), .valid_0 (wr_valid_0), .valid_1 (wr_valid_1),
        .rsp (wr_rsp),
        .bus_req (wr_req), .bus_gnt (wr_bus_gnt), .bus_msg (wr_msg),
        .msg_in_valid (msg_in_valid), .msg_in (msg_in_s)
    );

    coh_req_engine #(.cache_id(cache_id), .cache_num(cache_num), .is_read(1'b1)) u_rd_engine (
        .clk (clk), .rst_n (rst_n),
        .req_0 (msg_req_0), .req_1 (msg_req_1), .op_0 (msg_0), .op_1 (msg_1),
        .index_0 (msg_index_0), .index_1 (msg_index_1),
        .gnt_0 (rd_gnt_0), .gnt_1 (rd_gnt_1), .valid_0 (rd_valid_0), .valid_1 (rd_valid_1),
        .rsp (rd_rsp),
        .bus_req (rd_req), .bus_gnt (rd_bus_gnt), .bus_msg (rd_msg),
        .msg_in_valid (msg_in_valid), .msg_in (msg_in_s)
    );

    coh_snoop_responder #(.cache_id(cache_id), .cache_num(cache_num)) u_snoop (
        .clk (clk), .rst_n (rst_n),
        .msg_in_valid (msg_in_valid), .msg_in (msg_in_s),
        .acc_req (acc_req), .acc_cmd (acc_cmd), .acc_index (acc_index),
        .acc_gnt (acc_gnt), .acc_status (acc_status),
        .bus_req (snp_req), .bus_gnt (snp_bus_gnt), .bus_msg (snp_msg)
    );

    coh_bus_arbiter u_bus_arb (
        .clk (clk), .rst_n (rst_n),
        .req_wr (wr_req), .req_rd (rd_req), .req_snp (snp_req),
        .msg_wr (wr_msg), .msg_rd (rd_msg), .msg_snp (snp_msg),
        .gnt_wr (wr_bus_gnt), .gnt_rd (rd_bus_gnt), .gnt_snp (snp_bus_gnt),
        .bus_req (msg_req), .bus_msg (msg_out_s), .bus_gnt (msg_gnt)
    );

    // a port carries one opcode, so only one engine answers it
    assign msg_gnt_0   = wr_gnt_0 | rd_gnt_0;
    assign msg_gnt_1   = wr_gnt_1 | rd_gnt_1;
    assign msg_valid_0 = wr_valid_0 | rd_valid_0;
    assign msg_valid_1 = wr_valid_1 | rd_valid_1;
    assign msg_rsp_0   = ({4{wr_valid_0}} & wr_rsp) | ({4{rd_valid_0}} & rd_rsp);
    assign msg_rsp_1   = ({4{wr_valid_1}} & wr_rsp) | ({4{rd_valid_1}} & rd_rsp);

endmodule

// ==== dv/tb_coh_msg_ctrl.sv ====
`timescale 1ns/1ps

module tb_coh_msg_ctrl;

    logic        clk;
    logic        rst_n;
    logic        msg_req_0;
    logic [3:0]  msg_0;
    logic [31:0] msg_index_0;
    logic        msg_gnt_0;
    logic [3:0]  msg_rsp_0;
    logic        msg_valid_0;
    logic        msg_req_1;
    logic [3:0]  msg_1;
    logic [31:0] msg_index_1;
    logic        msg_gnt_1;
    logic [3:0]  msg_rsp_1;
    logic        msg_valid_1;
    logic        acc_req;
    logic [2:0]  acc_cmd;
    logic [31:0] acc_index;
    logic        acc_gnt;
    logic [2:0]  acc_status;
    logic        msg_req;
    logic        msg_gnt;
    logic [39:0] msg;
    logic        msg_in_valid;
    logic [39:0] msg_in;

    coh_msg_ctrl #(.cache_id(1), .cache_num(3)) i_dut (.*);

    always #5 clk = ~clk;

    int                errors;
    int                checks;
    int                cyc;
    logic [31:0]       rng;
    string             test_name;
    coh_pkg::coh_msg_t out_q[$];     // everything the bus took
    coh_pkg::coh_msg_t bcast_q[$];   // broadcasts still to be answered
    coh_pkg::coh_msg_t pend_msg[$];  // incoming messages waiting for their slot
    int                pend_due[$];
    logic [2:0]        acc_cmd_q[$];
    logic [31:0]       acc_idx_q[$];
    int                g0_cnt, g1_cnt, v0_cnt, v1_cnt;
    int                acks_done, acks_at_v, v0_at_g1;
    logic [3:0]        rsp0, rsp1;
    logic [3:0]        rd_ack0, rd_ack2;
    logic [2:0]        cur_status;
    logic              stalled;
    logic [39:0]       stall_msg;
    coh_pkg::coh_msg_t mon_msg;
    coh_pkg::coh_msg_t bc;
    logic [31:0]       t_kind, t_port, t_x, t_y, t_idx, t_st, t_e0, t_e1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int count_addr(input logic [31:0] a);
        int n = 0;
        foreach (out_q[i]) if (out_q[i].addr == a) n++;
        return n;
    endfunction

    function automatic logic [3:0] op_at_addr(input logic [31:0] a);
        logic [3:0] op = 4'hf;
        foreach (out_q[i]) if (out_q[i].addr == a) op = out_q[i].op;
        return op;
    endfunction

    task automatic compare_value(input string what, input logic [39:0] exp,
                                 input logic [39:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // ports, bus and array as seen on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            if (msg_gnt_0) g0_cnt++;
            if (msg_gnt_1) begin
                g1_cnt++;
                v0_at_g1 = v0_cnt;
            end
            if (msg_valid_0) begin
                v0_cnt++;
                rsp0 = msg_rsp_0;
                acks_at_v = acks_done;
            end
            if (msg_valid_1) begin
                v1_cnt++;
                rsp1 = msg_rsp_1;
                acks_at_v = acks_done;
            end
            if (stalled) begin
                compare_value("bus message under back-pressure", stall_msg, msg);
            end
            stalled   = msg_req && !msg_gnt;
            stall_msg = msg;
            if (msg_req && msg_gnt) begin
                mon_msg = msg;
                out_q.push_back(mon_msg);
                if (mon_msg.op[2] && mon_msg.ra == 2'd3) bcast_q.push_back(mon_msg);
            end
            if (acc_req && acc_gnt) begin
                acc_cmd_q.push_back(acc_cmd);
                acc_idx_q.push_back(acc_index);
            end
        end
    end

    task automatic schedule_ack(input logic [1:0] cache, input logic [3:0] op,
                                input logic [31:0] addr);
        rng = xorshift(rng);
        pend_msg.push_back({op, cache, 2'd1, addr});
        pend_due.push_back(cyc + 1 + int'(rng[2:0]));
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            rng = xorshift(rng);
            msg_gnt = msg_req && rng[3];  // withheld about half the time
            rng = xorshift(rng);
            acc_gnt = acc_req && rng[4];
            acc_status = cur_status;
            while (bcast_q.size() > 0) begin
                bc = bcast_q.pop_front();
                schedule_ack(2'd0, (bc.op == coh_pkg::wr_req) ? 4'h0 : rd_ack0, bc.addr);
                schedule_ack(2'd2, (bc.op == coh_pkg::wr_req) ? 4'h0 : rd_ack2, bc.addr);
            end
            msg_in_valid = 1'b0;
            for (int i = 0; i < pend_msg.size(); i++) begin
                if (!msg_in_valid && pend_due[i] <= cyc) begin
                    msg_in = pend_msg[i];
                    msg_in_valid = 1'b1;
                    if (!pend_msg[i].op[2] && pend_msg[i].ra == 2'd1) acks_done++;
                    pend_msg.delete(i);
                    pend_due.delete(i);
                end
            end
        end
    end

    task automatic drive_ports(input logic en0, input logic [3:0] op0, input logic [31:0] ix0,
                               input logic en1, input logic [3:0] op1, input logic [31:0] ix1);
        @(negedge clk);
        msg_req_0 = en0;
        msg_0 = op0;
        msg_index_0 = ix0;
        msg_req_1 = en1;
        msg_1 = op1;
        msg_index_1 = ix1;
        for (int t = 0; t < 200 && (msg_req_0 || msg_req_1); t++) begin
            @(negedge clk);
            if (g0_cnt > 0) msg_req_0 = 1'b0;
            if (g1_cnt > 0) msg_req_1 = 1'b0;
        end
        if (msg_req_0 || msg_req_1) begin
            errors++;
            $display("timeout waiting for a port grant in %s", test_name);
            msg_req_0 = 1'b0;
            msg_req_1 = 1'b0;
        end
    endtask

    task automatic inject_snoop(input logic [3:0] op, input logic [1:0] ta,
                                input logic [31:0] addr);
        pend_msg.push_back({op, ta, 2'd3, addr});
        pend_due.push_back(cyc);
    endtask

    task automatic wait_idle(input int nv0, input int nv1, input int nout);
        int t;
        for (t = 0; t < 500; t++) begin
            @(negedge clk);
            if (v0_cnt >= nv0 && v1_cnt >= nv1 && out_q.size() >= nout && pend_msg.size() == 0
                && bcast_q.size() == 0 && !msg_req && !acc_req) break;
        end
        if (t == 500) begin
            errors++;
            $display("timeout waiting for the DUT to finish %s", test_name);
        end
        repeat (6) @(negedge clk);  // room for stray pulses
    endtask

    task automatic run_line();
        logic [3:0]  op;
        logic        p;
        logic [31:0] i1;
        logic [31:0] i2;
        g0_cnt = 0;
        g1_cnt = 0;
        v0_cnt = 0;
        v1_cnt = 0;
        acks_done = 0;
        v0_at_g1 = -1;
        out_q.delete();
        acc_cmd_q.delete();
        acc_idx_q.delete();
        rd_ack0 = t_x[3:0];
        rd_ack2 = t_y[3:0];
        cur_status = t_st[2:0];
        p = t_port[0];
        i1 = t_idx + 32'h40;
        i2 = t_idx + 32'h80;
        if (t_kind < 2) begin
            op = (t_kind == 1) ? coh_pkg::rd_req : coh_pkg::wr_req;
            drive_ports(!p, op, t_idx, p, op, t_idx);
            wait_idle(p ? 0 : 1, p ? 1 : 0, 1);
            compare_value("grants", 40'd1, 40'(p ? g1_cnt : g0_cnt));
            compare_value("valids", 40'd1, 40'(p ? v1_cnt : v0_cnt));
            compare_value("other port valids", 40'd0, 40'(p ? v0_cnt : v1_cnt));
            compare_value("response", 40'(t_e0[3:0]), 40'(p ? rsp1 : rsp0));
            compare_value("acks before valid", 40'd2, 40'(acks_at_v));
            compare_value("broadcasts", 40'd1, 40'(out_q.size()));
            if (out_q.size() > 0) compare_value("broadcast", {op, 2'd1, 2'd3, t_idx}, out_q[0]);
        end else if (t_kind == 2) begin
            inject_snoop(t_x[3:0], t_y[1:0], t_idx);
            wait_idle(0, 0, (t_e1 == 8) ? 0 : 1);
            if (t_e1 == 8) begin
                compare_value("accesses", 40'd0, 40'(acc_cmd_q.size()));
                compare_value("replies", 40'd0, 40'(out_q.size()));
            end else begin
                compare_value("accesses", (t_e1 == 32'hf) ? 40'd1 : 40'd2,
                              40'(acc_cmd_q.size()));
                if (acc_cmd_q.size() > 0) begin
                    compare_value("first command", 40'd0, 40'(acc_cmd_q[0]));
                    compare_value("access index", 40'(t_idx), 40'(acc_idx_q[0]));
                end
                if (acc_cmd_q.size() > 1) begin
                    compare_value("second command", 40'(t_e1[2:0]), 40'(acc_cmd_q[1]));
                    compare_value("second access index", 40'(t_idx), 40'(acc_idx_q[1]));
                end
                compare_value("replies", 40'd1, 40'(out_q.size()));
                if (out_q.size() > 0) begin
                    compare_value("reply", {t_e0[3:0], 2'd1, t_y[1:0], t_idx}, out_q[0]);
                end
            end
        end else begin
            if (t_kind == 5) inject_snoop(coh_pkg::rd_req, 2'd0, i2);
            op = (t_kind == 3) ? coh_pkg::wr_req : coh_pkg::rd_req;
            drive_ports(1'b1, coh_pkg::wr_req, t_idx, 1'b1, op, i1);
            wait_idle(1, 1, (t_kind == 5) ? 3 : 2);
            compare_value("port 0 grants", 40'd1, 40'(g0_cnt));
            compare_value("port 1 grants", 40'd1, 40'(g1_cnt));
            compare_value("port 0 valids", 40'd1, 40'(v0_cnt));
            compare_value("port 1 valids", 40'd1, 40'(v1_cnt));
            compare_value("port 0 response", 40'(t_e0[3:0]), 40'(rsp0));
            compare_value("port 1 response", 40'((t_kind == 3) ? t_e0[3:0] : t_e1[3:0]),
                          40'(rsp1));
            compare_value("messages", (t_kind == 5) ? 40'd3 : 40'd2, 40'(out_q.size()));
            compare_value("port 0 broadcast", 40'd1, 40'(count_addr(t_idx)));
            compare_value("port 1 broadcast", 40'd1, 40'(count_addr(i1)));
            if (t_kind > 3) compare_value("valids before both grants", 40'd0, 40'(v0_at_g1));
            if (t_kind == 5) begin
                compare_value("snoop replies", 40'd1, 40'(count_addr(i2)));
                compare_value("snoop reply op",
                              (t_st[2:0] != 3'd0) ? 40'h3 : 40'h2, 40'(op_at_addr(i2)));
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    ln;
        string line;
        clk = 1'b0;
        rst_n = 1'b0;
        msg_req_0 = 1'b0;
        msg_0 = 4'h0;
        msg_index_0 = '0;
        msg_req_1 = 1'b0;
        msg_1 = 4'h0;
        msg_index_1 = '0;
        acc_gnt = 1'b0;
        acc_status = 3'd0;
        msg_gnt = 1'b0;
        msg_in_valid = 1'b0;
        msg_in = '0;
        errors = 0;
        checks = 0;
        cyc = 0;
        ln = 0;
        stalled = 1'b0;
        stall_msg = '0;
        cur_status = 3'd0;
        rng = 32'h5c02_046a;
        test_name = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_value("outputs", 40'd0, 40'({msg_req, acc_req, msg_gnt_0, msg_gnt_1,
                      msg_valid_0, msg_valid_1, msg_rsp_0, msg_rsp_1}));
        fd = $fopen("dv/coh_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                ln++;
                if (n > 0 && line.len() > 0 && line[0] != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h", t_kind, t_port, t_x, t_y,
                                t_idx, t_st, t_e0, t_e1);
                    if (n == 8) begin
                        test_name = $sformatf("trace line %0d", ln);
                        run_line();
                    end
                end
            end
            $fclose(fd);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/coh_trace.txt ====
# kind port ack0_or_snoop_op ack2_or_snoop_ta index status exp0 exp1 (all hex)
# kind 0 write, 1 read, 2 snoop, 3 two writes, 4 write+read, 5 write+read+snoop
0 0 0 0 00001000 0 0 0
0 1 0 0 00002040 0 0 0
1 0 3 2 00003000 0 3 0
1 1 2 2 00003100 0 2 0
1 0 2 3 00003200 0 3 0
2 0 4 0 00004000 1 0 3
2 0 4 0 00004100 0 0 f
2 0 5 0 00004200 2 3 1
2 0 5 0 00004300 0 2 f
2 0 5 1 00004400 1 f 8
2 0 2 0 00004500 1 f 8
3 0 0 0 00005000 0 0 0
4 0 3 2 00006000 0 0 3
4 0 2 2 00006400 0 0 2
5 0 2 2 00007000 4 0 2
5 0 3 2 00007400 0 0 3

// ==== coh_msg_ctrl.f ====
src/coh_pkg.sv
src/coh_rr_arbiter.sv
src/coh_sync_fifo.sv
src/coh_req_engine.sv
src/coh_snoop_responder.sv
src/coh_bus_arbiter.sv
src/coh_msg_ctrl.sv
dv/tb_coh_msg_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f coh_msg_ctrl.f --top-module tb_coh_msg_ctrl -o sim_coh
./obj_dir/sim_coh > sim.log
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log
